// ==== Bender.yml ====
package:
  name: uart6551

sources:
  - source/uartPkg.sv
  - source/uartBaudLut.sv
  - source/uartBaudGen.sv
  - source/uartTransmitter.sv
  - source/uartReceiver.sv
  - source/uartControl.sv
  - source/uartTop.sv
  - target: simulation
    files:
      - verif/uartTb.sv

// ==== source/uartBaudGen.sv ====
/* baud generator: down-counter giving one 16x oversampling tick
   every divisor clocks, restarts cleanly on a rate change */
module uartBaudGen
	import uartPkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic [divisorBits-1:0] divisor,
	output logic                   tick
);

	logic [divisorBits-1:0] count;    // clocks left until next tick
	logic [divisorBits-1:0] lastDiv;  // divisor seen last cycle
	logic [divisorBits-1:0] reload;

	assign reload = divisor - divisorBits'(1);  // period is divisor clocks

	always_ff @(posedge clk) begin
		if (reset) begin
			count   <= reload;
			lastDiv <= divisor;
			tick    <= 1'b0;
		end else if (divisor != lastDiv) begin
			count   <= reload;     // new rate, start over at once
			lastDiv <= divisor;
			tick    <= 1'b0;
		end else if (count == '0) begin
			count   <= reload;
			tick    <= 1'b1;       // one clock wide
		end else begin
			count   <= count - divisorBits'(1);
			tick    <= 1'b0;
		end
	end

	// ==========================================================
	// checks
	// ==========================================================
	// only divisor 1 may tick every clock, also holds through a
	// change once the new rate has settled
	assert property (@(posedge clk) disable iff (reset)
		(divisor > 1 && $stable(divisor)) |-> !(tick && $past(tick)))
		else $error("baud tick high on two cycles in a row, divisor %0d", divisor);

endmodule

// ==== source/uartBaudLut.sv ====
/* baud rate lut: baud index to 16x divisor, the constants are
   worked out at elaboration from the clock frequency */
module uartBaudLut
	import uartPkg::*;
(
	input  logic [baudIndexBits-1:0] baudIndex,
	output logic [divisorBits-1:0]   divisor
);

	localparam int tableSize = 2 ** baudIndexBits;        // every index gets an entry
	localparam int lastIndex = $size(baudCentiTable) - 1; // 21, 921600 baud

	// ==========================================================
	// divisor = clk / (16 * baud), rounded to nearest
	// ==========================================================
	// clock in MHz times 1e8 gives clocks per second times 100,
	// which cancels the hundredths in the table
	function automatic logic [divisorBits-1:0] calcDivisor(input int idx);
		longint num;
		longint den;
		int     sel;
		sel = (idx == 0 || idx > lastIndex) ? defaultBaudIndex : idx; // fall back to 9600
		num = longint'(clkFreqMhz) * longint'(100_000_000);
		den = longint'(oversample) * longint'(baudCentiTable[sel]);
		return divisorBits'((num + den / 2) / den);                   // round half up
	endfunction

	logic [divisorBits-1:0] divTable [tableSize];  // constant rom

	// at 100 MHz this comes out as
	//   50:125000  75:83333  109.92:56860  134.58:46441  150:41667
	//   300:20833  600:10417  1200:5208  1800:3472  2400:2604
	//   3600:1736  4800:1302  7200:868  9600:651  19200:326
	//   38400:163  57600:109  115200:54  230400:27  460800:14  921600:7
	for (genvar i = 0; i < tableSize; i++) begin : genTable
		assign divTable[i] = calcDivisor(i);  // folds to a constant
	end

	assign divisor = divTable[baudIndex];     // plain rom read

endmodule

// ==== source/uartControl.sv ====
/* uart control: config decode, tx and rx queues with credit
   accounting toward the host, loopback select */
module uartControl
	import uartPkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	// host configuration
	input  logic                     cfgValid,
	input  uartOp_e                  cfgOp,
	input  logic [baudIndexBits-1:0] cfgData,
	// host transmit
	input  logic                     txValid,
	input  logic [7:0]               txData,
	output logic                     txCredit,
	// host receive
	input  logic                     rxCreditReturn,
	output logic                     rxValid,
	output logic [7:0]               rxData,
	output logic                     rxFrameErr,
	// datapath
	output logic [baudIndexBits-1:0] baudIndex,
	output logic                     txStart,
	output logic [7:0]               txByte,
	input  logic                     txBusy,
	input  logic                     rxDone,
	input  logic [7:0]               rxByte,
	input  logic                     rxFrameErrBit,
	input  logic                     txd,
	input  logic                     rxd,
	output logic                     rxSerial
);

	logic loopback;

	// tx queue
	logic [7:0]                          txMem [txQueueDepth];
	logic [$clog2(txQueueDepth)-1:0]     txWr;
	logic [$clog2(txQueueDepth)-1:0]     txRd;
	logic [$clog2(txQueueDepth + 1)-1:0] txCount;
	logic                                txPush;
	logic                                txIssue;

	// rx queue, error bit on top
	logic [8:0]                          rxMem [rxQueueDepth];
	logic [$clog2(rxQueueDepth)-1:0]     rxWr;
	logic [$clog2(rxQueueDepth)-1:0]     rxRd;
	logic [$clog2(rxQueueDepth + 1)-1:0] rxCount;
	logic [3:0]                          rxCredits;  // granted by host, not yet used
	logic                                rxPush;
	logic                                rxDeliver;

	assign txPush    = txValid && (txCount != txQueueDepth);
	assign txIssue   = !txBusy && (txCount != 0) && !txStart;  // one start per idle
	assign rxPush    = rxDone && (rxCount != rxQueueDepth);    // full queue drops
	assign rxDeliver = (rxCount != 0) && (rxCredits != 0);
	assign rxSerial  = loopback ? txd : rxd;                   // echo path

	// ==========================================================
	// control state
	// ==========================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			baudIndex  <= baudIndexBits'(defaultBaudIndex);
			loopback   <= 1'b0;
			txWr       <= '0;
			txRd       <= '0;
			txCount    <= '0;
			txStart    <= 1'b0;
			txCredit   <= 1'b0;
			rxWr       <= '0;
			rxRd       <= '0;
			rxCount    <= '0;
			rxCredits  <= '0;
			rxValid    <= 1'b0;
			rxFrameErr <= 1'b0;
		end else begin
			if (cfgValid && cfgOp == opSetBaud)
				baudIndex <= cfgData;
			if (cfgValid && cfgOp == opSetLoopback)
				loopback <= cfgData[0];

			txStart  <= txIssue;
			txCredit <= txIssue;      // byte left the queue, credit back
			if (txPush)
				txWr <= txWr + 1'b1;
			if (txIssue)
				txRd <= txRd + 1'b1;
			if (txPush && !txIssue)
				txCount <= txCount + 1'b1;
			else if (!txPush && txIssue)
				txCount <= txCount - 1'b1;

			rxValid    <= rxDeliver;
			rxFrameErr <= rxDeliver && rxMem[rxRd][8];
			if (rxPush)
				rxWr <= rxWr + 1'b1;
			if (rxDeliver)
				rxRd <= rxRd + 1'b1;
			if (rxPush && !rxDeliver)
				rxCount <= rxCount + 1'b1;
			else if (!rxPush && rxDeliver)
				rxCount <= rxCount - 1'b1;
			if (rxCreditReturn && !rxDeliver)
				rxCredits <= rxCredits + 4'd1;
			else if (!rxCreditReturn && rxDeliver)
				rxCredits <= rxCredits - 4'd1;
		end
	end

	// ==========================================================
	// queue storage and payload
	// ==========================================================
	always_ff @(posedge clk) begin
		if (txPush)
			txMem[txWr] <= txData;
		if (txIssue)
			txByte <= txMem[txRd];
		if (rxPush)
			rxMem[rxWr] <= {rxFrameErrBit, rxByte};
		if (rxDeliver)
			rxData <= rxMem[rxRd][7:0];
	end

	// host spent a tx credit it never had
	assert property (@(posedge clk) disable iff (reset)
		txValid |-> (txCount != txQueueDepth))
		else $error("txValid with tx queue full, host credit violation");

	// more credits granted than the counter holds
	assert property (@(posedge clk) disable iff (reset)
		(rxCreditReturn && !rxDeliver) |-> (rxCredits != 4'd15))
		else $error("rx credit count would exceed 15");

endmodule

// ==== source/uartPkg.sv ====
/* uart package: shared sizes, centibaud table and state/opcode enums
   for the 6551-style serial port */
package uartPkg;

	// ==========================================================
	// clocking and divisor sizing
	// ==========================================================
	localparam int clkFreqMhz       = 100;  // system clock, edit for other boards
	localparam int divisorBits      = 24;   // wide enough for 50 baud at 100 MHz
	localparam int baudIndexBits    = 5;
	localparam int defaultBaudIndex = 14;   // 9600 baud

	// rates in hundredths of a baud, index 0 unused
	localparam logic [31:0] baudCentiTable [22] = '{
		32'd0,        32'd5000,     32'd7500,     32'd10992,
		32'd13458,    32'd15000,    32'd30000,    32'd60000,
		32'd120000,   32'd180000,   32'd240000,   32'd360000,
		32'd480000,   32'd720000,   32'd960000,   32'd1920000,
		32'd3840000,  32'd5760000,  32'd11520000, 32'd23040000,
		32'd46080000, 32'd92160000
	};

	// ==========================================================
	// framing and queues
	// ==========================================================
	localparam int oversample   = 16;  // ticks per bit
	localparam int midSample    = 8;   // tick of a bit that gets sampled
	localparam int txQueueDepth = 4;   // also host's starting tx credits
	localparam int rxQueueDepth = 4;

	typedef enum logic [1:0] {
		opNop,
		opSetBaud,
		opSetLoopback
	} uartOp_e;

	typedef enum logic [1:0] {txIdle, txStart, txData, txStop} txState_e;

	typedef enum logic [1:0] {rxIdle, rxStart, rxData, rxStop} rxState_e;

endpackage

// ==== source/uartReceiver.sv ====
/* receiver: finds a start edge, samples at mid bit with 16x
   oversampling and flags a low stop bit as a framing error */
module uartReceiver
	import uartPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       tick,
	input  logic       rxd,
	output logic       rxDone,
	output logic [7:0] rxByte,
	output logic       rxFrameErrBit
);

	rxState_e   state;
	logic       rxMeta;      // first synchronizer stage
	logic       rxSync;      // safe to use
	logic       rxLast;      // rxSync one clock ago
	logic       fallEdge;
	logic [3:0] tickCnt;
	logic [2:0] bitCnt;
	logic [7:0] shifter;
	logic       midTick;     // start bit recheck point
	logic       sampleNow;   // middle of a data or stop bit

	assign fallEdge  = rxLast && !rxSync;  // edge, not level: a break won't retrigger
	assign midTick   = tick && (tickCnt == 4'(midSample - 1));
	assign sampleNow = tick && (tickCnt == 4'(oversample - 1));

	// ==========================================================
	// synchronizer and frame sequencer
	// ==========================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			rxMeta        <= 1'b1;
			rxSync        <= 1'b1;
			rxLast        <= 1'b1;
			state         <= rxIdle;
			tickCnt       <= '0;
			bitCnt        <= '0;
			rxDone        <= 1'b0;
			rxFrameErrBit <= 1'b0;
		end else begin
			rxMeta <= rxd;
			rxSync <= rxMeta;
			rxLast <= rxSync;
			rxDone <= 1'b0;              // pulse
			case (state)
				rxIdle: begin
					if (fallEdge) begin
						state   <= rxStart;
						tickCnt <= '0;
					end
				end
				rxStart: begin
					if (midTick) begin
						tickCnt <= '0;
						bitCnt  <= '0;
						state   <= rxSync ? rxIdle : rxData;  // glitch, give up
					end else if (tick)
						tickCnt <= tickCnt + 4'd1;
				end
				rxData: begin
					if (sampleNow) begin
						tickCnt <= '0;
						bitCnt  <= bitCnt + 3'd1;
						if (bitCnt == 3'd7)
							state <= rxStop;
					end else if (tick)
						tickCnt <= tickCnt + 4'd1;
				end
				default: begin           // stop bit
					if (sampleNow) begin
						tickCnt       <= '0;
						rxDone        <= 1'b1;
						rxFrameErrBit <= !rxSync;  // stop must be high
						state         <= rxIdle;
					end else if (tick)
						tickCnt <= tickCnt + 4'd1;
				end
			endcase
		end
	end

	// payload, data arrives lsb first
	always_ff @(posedge clk) begin
		if (state == rxData && sampleNow)
			shifter <= {rxSync, shifter[7:1]};
		if (state == rxStop && sampleNow)
			rxByte <= shifter;
	end

endmodule

// ==== source/uartTop.sv ====
/* uart top: control with queues plus baud lut, baud generator,
   transmitter and receiver */
module uartTop
	import uartPkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     cfgValid,
	input  uartOp_e                  cfgOp,
	input  logic [baudIndexBits-1:0] cfgData,
	input  logic                     txValid,
	input  logic [7:0]               txData,
	output logic                     txCredit,
	input  logic                     rxCreditReturn,
	output logic                     rxValid,
	output logic [7:0]               rxData,
	output logic                     rxFrameErr,
	input  logic                     rxd,
	output logic                     txd
);

	logic [baudIndexBits-1:0] baudIndex;
	logic [divisorBits-1:0]   divisor;
	logic                     tick;           // 16x bit rate
	logic                     txStart;
	logic [7:0]               txByte;
	logic                     txBusy;
	logic                     rxDone;
	logic [7:0]               rxByte;
	logic                     rxFrameErrBit;
	logic                     rxSerial;       // rxd or looped txd

	uartControl control (
		.clk           (clk),
		.reset         (reset),
		.cfgValid      (cfgValid),
		.cfgOp         (cfgOp),
		.cfgData       (cfgData),
		.txValid       (txValid),
		.txData        (txData),
		.txCredit      (txCredit),
		.rxCreditReturn(rxCreditReturn),
		.rxValid       (rxValid),
		.rxData        (rxData),
		.rxFrameErr    (rxFrameErr),
		.baudIndex     (baudIndex),
		.txStart       (txStart),
		.txByte        (txByte),
		.txBusy        (txBusy),
		.rxDone        (rxDone),
		.rxByte        (rxByte),
		.rxFrameErrBit (rxFrameErrBit),
		.txd           (txd),
		.rxd           (rxd),
		.rxSerial      (rxSerial)
	);

	uartBaudLut baudLut (
		.baudIndex(baudIndex),
		.divisor  (divisor)
	);

	uartBaudGen baudGen (
		.clk    (clk),
		.reset  (reset),
		.divisor(divisor),
		.tick   (tick)
	);

	uartTransmitter transmitter (
		.clk    (clk),
		.reset  (reset),
		.tick   (tick),
		.txStart(txStart),
		.txByte (txByte),
		.txBusy (txBusy),
		.txd    (txd)
	);

	uartReceiver receiver (
		.clk          (clk),
		.reset        (reset),
		.tick         (tick),
		.rxd          (rxSerial),
		.rxDone       (rxDone),
		.rxByte       (rxByte),
		.rxFrameErrBit(rxFrameErrBit)
	);

endmodule

// ==== source/uartTransmitter.sv ====
/* transmitter: shifts one byte out as an 8N1 frame on txd,
   16 ticks per bit, lsb first */
module uartTransmitter
	import uartPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       tick,
	input  logic       txStart,
	input  logic [7:0] txByte,
	output logic       txBusy,
	output logic       txd
);

	txState_e   state;
	logic [3:0] tickCnt;   // tick within the current bit
	logic [2:0] bitCnt;    // data bit number
	logic [7:0] shifter;   // remaining data bits
	logic       bitLevel;  // level of the bit in flight
	logic       lastTick;  // final tick of a bit

	assign lastTick = tick && (tickCnt == 4'(oversample - 1));

	// the port txStart hides the state literal, hence the package prefix
	always_comb begin
		case (state)
			uartPkg::txStart: bitLevel = 1'b0;        // start bit
			txData:           bitLevel = shifter[0];  // lsb first
			default:          bitLevel = 1'b1;        // stop bit and idle
		endcase
	end

	// ==========================================================
	// frame sequencer
	// ==========================================================
	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= txIdle;
			tickCnt <= '0;
			bitCnt  <= '0;
			txBusy  <= 1'b0;
			txd     <= 1'b1;      // line idles high
		end else if (state == txIdle) begin
			if (txStart) begin
				state   <= uartPkg::txStart;
				tickCnt <= '0;
				bitCnt  <= '0;
				txBusy  <= 1'b1;
			end
		end else if (tick) begin
			tickCnt <= tickCnt + 4'd1;   // wraps after 16
			if (tickCnt == '0)
				txd <= bitLevel;         // bit edge on its first tick
			if (lastTick) begin
				case (state)
					uartPkg::txStart: state <= txData;
					txData: begin
						bitCnt <= bitCnt + 3'd1;
						if (bitCnt == 3'd7)
							state <= txStop;
					end
					default: begin           // end of stop bit, 160th tick
						state  <= txIdle;
						txBusy <= 1'b0;
					end
				endcase
			end
		end
	end

	// payload
	always_ff @(posedge clk) begin
		if (state == txIdle && txStart)
			shifter <= txByte;
		else if (state == txData && lastTick)
			shifter <= shifter >> 1;
	end

	// a finished frame leaves the line high until the next start
	assert property (@(posedge clk) disable iff (reset) (state == txIdle) |-> txd)
		else $error("txd low while transmitter idle");

endmodule

// ==== verif/uartTb.sv ====
/* uart testbench: reset state, bit timing, loopback, credit flow and
   framing error checks against a reference divisor model */
module uartTb
	import uartPkg::*;
;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clockMhz = 100;
	localparam longint centiRates [22] = '{
		0,        5000,     7500,     10992,    13458,    15000,
		30000,    60000,    120000,   180000,   240000,   360000,
		480000,   720000,   960000,   1920000,  3840000,  5760000,
		11520000, 23040000, 46080000, 92160000
	};

	logic       clk;
	logic       reset;
	logic       cfgValid;
	uartOp_e    cfgOp;
	logic [4:0] cfgData;
	logic       txValid;
	logic [7:0] txData;
	logic       txCredit;
	logic       rxCreditReturn;
	logic       rxValid;
	logic [7:0] rxData;
	logic       rxFrameErr;
	logic       rxd;
	logic       txd;

	logic [8:0]  expectQ [$];           // {frameErr, byte} in send order
	logic [8:0]  expected;
	logic [31:0] rngState = 32'h8ee6;
	int errors = 0;
	int errorsBefore = 0;
	int testsRun = 0;
	int testsOk = 0;
	int txSent = 0;                     // host tx credits spent
	int txCreditSeen = 0;               // credits handed back
	int rxSeen = 0;

	uartTop DUT (
		.clk           (clk),
		.reset         (reset),
		.cfgValid      (cfgValid),
		.cfgOp         (cfgOp),
		.cfgData       (cfgData),
		.txValid       (txValid),
		.txData        (txData),
		.txCredit      (txCredit),
		.rxCreditReturn(rxCreditReturn),
		.rxValid       (rxValid),
		.rxData        (rxData),
		.rxFrameErr    (rxFrameErr),
		.rxd           (rxd),
		.txd           (txd)
	);

	// ==========================================================
	// reference model and helpers
	// ==========================================================
	function automatic longint divisorFor(input int index);
		longint num;
		longint den;
		int     sel;
		sel = (index == 0 || index > 21) ? 14 : index;  // 9600 fallback
		num = longint'(clockMhz) * 64'd100_000_000;
		den = 16 * centiRates[sel];
		return (num + den / 2) / den;                   // nearest
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
		assert (got === want)
		else begin
			$display("mismatch %s: got 0x%0h expected 0x%0h", name, got, want);
			errors++;
		end
	endtask

	// all drive tasks start and end 1 ns after a rising edge
	task automatic waitCycles(input longint n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic cfgWrite(input uartOp_e op, input logic [4:0] data);
		cfgValid = 1'b1;
		cfgOp    = op;
		cfgData  = data;
		waitCycles(1);
		cfgValid = 1'b0;
		cfgOp    = opNop;
	endtask

	task automatic grantRx(input int n);
		rxCreditReturn = 1'b1;          // one credit per cycle high
		waitCycles(n);
		rxCreditReturn = 1'b0;
	endtask

	task automatic sendByte(input logic [7:0] b, input bit echo);
		while (txQueueDepth - txSent + txCreditSeen <= 0)
			waitCycles(1);              // hold off until a credit is back
		txValid = 1'b1;
		txData  = b;
		txSent++;
		if (echo)
			expectQ.push_back({1'b0, b});
		waitCycles(1);
		txValid = 1'b0;
	endtask

	task automatic driveFrame(input logic [7:0] b, input logic stopLevel);
		logic [9:0] bits;
		bits = {stopLevel, b, 1'b0};    // start bit sent first
		for (int i = 0; i < 10; i++) begin
			rxd = bits[i];
			waitCycles(16 * divisorFor(21));
		end
		rxd = 1'b1;
	endtask

	task automatic waitDrain();
		while (expectQ.size() != 0)
			waitCycles(1);
	endtask

	task automatic measureStartBit(input int index);
		longint lowCount;
		lowCount = 0;
		cfgWrite(opSetBaud, 5'(index));
		waitCycles(4);
		sendByte(8'hA5, 1'b0);          // bit 0 high ends the start bit cleanly
		@(negedge clk);
		while (txd)
			@(negedge clk);
		while (!txd) begin
			lowCount++;
			@(negedge clk);
		end
		checkValue("start bit low clocks", 32'(lowCount), 32'(16 * divisorFor(index)));
		waitCycles(160 * divisorFor(index));  // rest of frame plus margin
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errors == errorsBefore) begin
			testsOk++;
			$display("test %0d %s: ok", testsRun, name);
		end else
			$display("test %0d %s: %0d errors", testsRun, name, errors - errorsBefore);
		errorsBefore = errors;
	endtask

	// ==========================================================
	// clock, comparison and watchdog
	// ==========================================================
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;          // 100 MHz
	end

	always @(negedge clk) begin
		if (!reset) begin
			if (txCredit)
				txCreditSeen++;
			if (rxValid) begin
				rxSeen++;
				assert (expectQ.size() != 0)
				else begin
					$display("rxValid with no byte outstanding, data 0x%h", rxData);
					errors++;
				end
				if (expectQ.size() != 0) begin
					expected = expectQ.pop_front();
					checkValue("rxData", rxData, expected[7:0]);
					checkValue("rxFrameErr", rxFrameErr, expected[8]);
				end
			end
		end
	end

	initial begin
		longint budgetNs;
		// 19 frames at index 21, one at index 19
		budgetNs = 2 * (19 * 160 * divisorFor(21) + 160 * divisorFor(19)) * 10 + 10_000;
		#(budgetNs);
		$display("watchdog expired before the tests finished");
		$display("tests failed");
		$finish;
	end

	// ==========================================================
	// test sequence
	// ==========================================================
	initial begin
		int start;
		reset          = 1'b1;
		cfgValid       = 1'b0;
		cfgOp          = opNop;
		cfgData        = '0;
		txValid        = 1'b0;
		txData         = '0;
		rxCreditReturn = 1'b0;
		rxd            = 1'b1;          // idle line
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		repeat (20) begin
			@(negedge clk);
			checkValue("txd", txd, 1'b1);
			checkValue("rxValid", rxValid, 1'b0);
			checkValue("txCredit", txCredit, 1'b0);
			checkValue("rxFrameErr", rxFrameErr, 1'b0);
		end
		waitCycles(1);
		endTest("reset state");

		measureStartBit(21);
		measureStartBit(19);
		endTest("bit timing");

		cfgWrite(opSetBaud, 5'd21);
		cfgWrite(opSetLoopback, 5'd1);
		grantRx(8);
		for (int i = 0; i < 8; i++) begin
			rngState = xorshift32(rngState);
			sendByte(rngState[7:0], 1'b1);
		end
		waitDrain();
		endTest("loopback data");

		grantRx(4);
		start = txCreditSeen;
		for (int i = 0; i < 4; i++)
			sendByte(8'h30 + 8'(i), 1'b1);  // consecutive cycles
		waitDrain();
		checkValue("txCredit pulses", txCreditSeen - start, 4);
		endTest("tx credits");

		grantRx(1);
		start = rxSeen;
		for (int i = 0; i < 4; i++)
			sendByte(8'hC0 + 8'(i), 1'b1);
		waitCycles(5 * 160 * divisorFor(21));  // all four frames received
		checkValue("rxValid count on one credit", rxSeen - start, 1);
		grantRx(3);
		waitDrain();
		waitCycles(50);
		checkValue("rxValid count", rxSeen - start, 4);
		endTest("rx back-pressure");

		cfgWrite(opSetLoopback, 5'd0);
		grantRx(1);
		expectQ.push_back({1'b1, 8'h3C});
		driveFrame(8'h3C, 1'b0);        // low stop bit
		waitDrain();
		waitCycles(160 * divisorFor(21));
		endTest("framing error");

		$display("%0d of %0d tests ok, %0d errors", testsOk, testsRun, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== vlog.f ====
source/uartPkg.sv
source/uartBaudLut.sv
source/uartBaudGen.sv
source/uartTransmitter.sv
source/uartReceiver.sv
source/uartControl.sv
source/uartTop.sv
verif/uartTb.sv
